// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_stage_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= sim passed
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/stage_model.svh ====
`ifndef STAGE_MODEL_SVH
`define STAGE_MODEL_SVH

logic [L*LANE_W-1:0] cb_mirror [CB_DEPTH];  // rows as loaded
logic [LANE_W-1:0]   tbuf_mirror [L][L];   // [row][lane]
int                  credits;               // held upstream

// relu zeroes a negative lane and leaky floors v / 2**LEAKY_SHIFT
function automatic logic [LANE_W-1:0] activate_lane(input logic signed [LANE_W-1:0] v,
                                                     input act_e act);
  int iv;
  int div;
  iv  = int'(v);
  div = 2 ** LEAKY_SHIFT;
  if (iv >= 0) begin
    return v;
  end
  if (act == ACT_RELU) begin
    return '0;
  end
  iv = (iv - (div - 1)) / div;  // floor for negatives
  return iv[LANE_W-1:0];
endfunction

// output lane k is built from the lane the direction names
function automatic logic [L*LANE_W-1:0] expected_row(input logic [L*LANE_W-1:0] coef,
                                                      input src_e src, input act_e act,
                                                      input dir_e dir, input logic half);
  logic [LANE_W-1:0]   in_l [L];
  logic [L*LANE_W-1:0] out;
  int                  h;
  h   = L / 2;
  out = '0;
  for (int k = 0; k < L; k++) begin
    in_l[k] = coef[k*LANE_W +: LANE_W];
    if (src == SRC_NL) begin
      in_l[k] = activate_lane(in_l[k], act);
    end
  end
  for (int k = 0; k < L; k++) begin
    case (dir)
      DIR_POS: out[k*LANE_W +: LANE_W] = in_l[k];
      DIR_NEG: out[k*LANE_W +: LANE_W] = in_l[L-1-k];
      DIR_NEW: begin
        if (half && k < h) begin
          out[k*LANE_W +: LANE_W] = in_l[k];
        end else if (!half && k >= h) begin
          out[k*LANE_W +: LANE_W] = in_l[k-h];
        end
      end
      default: out[k*LANE_W +: LANE_W] = '0;
    endcase
  end
  return out;
endfunction

function automatic logic [L*LANE_W-1:0] mirror_column(input int c);
  logic [L*LANE_W-1:0] col;
  col = '0;
  for (int r = 0; r < L; r++) begin
    col[r*LANE_W +: LANE_W] = tbuf_mirror[r][c];
  end
  return col;
endfunction

`endif

// ==== bench/tb_stage_top.sv ====
`timescale 1ns/10ps

module tb_stage_top;

  import stage_pkg::*;

  localparam int L        = 4;
  localparam int LANE_W   = 16;
  localparam int CB_DEPTH = 16;
  localparam int CREDITS  = 4;
  localparam int ADDR_W   = $clog2(CB_DEPTH);
  localparam int ROW_W    = $clog2(L);

  localparam logic [31:0] SEED = 32'd24512;
  localparam int N_SPACED = 8;
  localparam int N_NL     = 8;
  localparam int N_NEW    = 8;
  localparam int N_BURST  = 16;
  localparam int N_CMDS   = N_SPACED + N_NL + N_NEW + N_BURST;
  localparam int N_READS  = 5 * L;
  localparam int WATCHDOG_CYCLES = CB_DEPTH + N_CMDS * 6 + N_READS * 2 + 100;

  logic                  clk;
  logic                  sys_rst;
  logic                  i_cb_we;
  logic [ADDR_W-1:0]     i_cb_waddr;
  logic [L*LANE_W-1:0]   i_cb_wdata;
  logic                  i_cmd_valid;
  src_e                  i_cmd_src;
  act_e                  i_cmd_act;
  dir_e                  i_cmd_dir;
  logic                  i_cmd_half;
  logic [ADDR_W-1:0]     i_cmd_addr;
  logic [ROW_W-1:0]      i_cmd_row;
  logic                  o_credit;
  logic [ROW_W-1:0]      i_rd_col;
  logic [L*LANE_W-1:0]   o_rd_data;

  logic [31:0]         rng_state;
  int                  errors;
  int                  checks;
  int                  neg_cyc;
  int                  due_q [$];       // negedge index of each expected credit
  int                  pend_row [$];
  logic [L*LANE_W-1:0] pend_data [$];

  `include "stage_model.svh"

  stage_top #(
    .L        (L),
    .LANE_W   (LANE_W),
    .CB_DEPTH (CB_DEPTH),
    .CREDITS  (CREDITS)
  ) UUT (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_cb_we     (i_cb_we),
    .i_cb_waddr  (i_cb_waddr),
    .i_cb_wdata  (i_cb_wdata),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd_src   (i_cmd_src),
    .i_cmd_act   (i_cmd_act),
    .i_cmd_dir   (i_cmd_dir),
    .i_cmd_half  (i_cmd_half),
    .i_cmd_addr  (i_cmd_addr),
    .i_cmd_row   (i_cmd_row),
    .o_credit    (o_credit),
    .i_rd_col    (i_rd_col),
    .o_rd_data   (o_rd_data)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [L*LANE_W-1:0] random_row();
    logic [L*LANE_W-1:0] row;
    logic [31:0]         r;
    row = '0;
    for (int k = 0; k < L; k++) begin
      r = next_random();
      row[k*LANE_W +: LANE_W] = r[LANE_W-1:0];
    end
    return row;
  endfunction

  // inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic send_cmd(input src_e src, input act_e act, input dir_e dir,
                          input logic half, input int addr, input int row);
    while (credits == 0) begin
      step();
    end
    pend_row.push_back(row);
    pend_data.push_back(expected_row(cb_mirror[addr], src, act, dir, half));
    i_cmd_valid = 1'b1;
    i_cmd_src   = src;
    i_cmd_act   = act;
    i_cmd_dir   = dir;
    i_cmd_half  = half;
    i_cmd_addr  = addr[ADDR_W-1:0];
    i_cmd_row   = row[ROW_W-1:0];
    credits--;
    step();
    i_cmd_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (credits != CREDITS) begin
      step();
    end
  endtask

  task automatic read_column(input int c);
    logic [L*LANE_W-1:0] exp_col;
    i_rd_col = c[ROW_W-1:0];
    @(posedge clk);  // column sampled here
    @(negedge clk);
    exp_col = mirror_column(c);
    checks++;
    assert (o_rd_data === exp_col) else begin
      errors++;
      $display("mismatch at %0t: o_rd_data col %0d got %h expected %h",
               $time, c, o_rd_data, exp_col);
    end
    step();
  endtask

  task automatic read_all();
    for (int c = 0; c < L; c++) begin
      read_column(c);
    end
  endtask

  // credit check, mirror update and credit return on the falling edge
  always @(negedge clk) begin : credit_monitor
    logic exp_credit;
    neg_cyc++;
    if (!sys_rst) begin
      exp_credit = (due_q.size() > 0 && due_q[0] == neg_cyc);
      checks++;
      assert (o_credit === exp_credit) else begin
        errors++;
        $display("mismatch at %0t: o_credit got %b expected %b", $time, o_credit, exp_credit);
      end
      if (exp_credit) begin
        void'(due_q.pop_front());
        for (int c = 0; c < L; c++) begin
          tbuf_mirror[pend_row[0]][c] = pend_data[0][c*LANE_W +: LANE_W];
        end
        void'(pend_row.pop_front());
        void'(pend_data.pop_front());
      end
      if (o_credit === 1'b1) begin
        credits++;
      end
      if (i_cmd_valid) begin
        due_q.push_back(neg_cyc + 5);  // write at edge 4 and credit one negedge later
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

  initial begin : stimulus
    logic [31:0]         r;
    logic [L*LANE_W-1:0] row;
    clk = 1'b0;
    sys_rst = 1'b1;
    i_cb_we = 1'b0;
    i_cb_waddr = '0;
    i_cb_wdata = '0;
    i_cmd_valid = 1'b0;
    i_cmd_src = SRC_COEF;
    i_cmd_act = ACT_RELU;
    i_cmd_dir = DIR_IDLE;
    i_cmd_half = 1'b0;
    i_cmd_addr = '0;
    i_cmd_row = '0;
    i_rd_col = '0;
    rng_state = SEED;
    errors = 0;
    checks = 0;
    neg_cyc = 0;
    credits = CREDITS;
    for (int i = 0; i < L; i++) begin
      for (int c = 0; c < L; c++) begin
        tbuf_mirror[i][c] = '0;
      end
    end
    repeat (4) @(posedge clk);
    #1;
    sys_rst = 1'b0;

    read_all();  // cleared by reset

    for (int a = 0; a < CB_DEPTH; a++) begin
      row = random_row();
      i_cb_we    = 1'b1;
      i_cb_waddr = a[ADDR_W-1:0];
      i_cb_wdata = row;
      cb_mirror[a] = row;
      step();
    end
    i_cb_we = 1'b0;

    // one raw coefficient command at a time
    for (int i = 0; i < N_SPACED; i++) begin
      r = next_random();
      send_cmd(SRC_COEF, act_e'(r[9]), r[8] ? DIR_NEG : DIR_POS, r[10], int'(r[3:0]), i % L);
      wait_drain();
    end
    read_all();

    for (int i = 0; i < N_NL; i++) begin
      r = next_random();
      send_cmd(SRC_NL, act_e'(i % 2), r[8] ? DIR_NEG : DIR_POS, r[10], int'(r[3:0]), i % L);
    end
    wait_drain();
    read_all();

    // half placement with every fourth command idle
    for (int i = 0; i < N_NEW; i++) begin
      r = next_random();
      send_cmd(src_e'(r[6]), act_e'(r[7]), (i % 4 == 3) ? DIR_IDLE : DIR_NEW,
               ((i / 2) % 2) == 1, int'(r[3:0]), i % L);
    end
    wait_drain();
    read_all();

    for (int i = 0; i < N_BURST; i++) begin
      r = next_random();
      send_cmd(src_e'(r[6]), act_e'(r[7]), dir_e'(r[9:8]), r[10], int'(r[3:0]),
               int'(r[5:4]));
    end
    wait_drain();
    read_all();

    checks++;
    assert (due_q.size() == 0 && pend_row.size() == 0) else begin
      errors++;
      $display("rows lost at the end: %0d expected writes and %0d credits never seen",
               pend_row.size(), due_q.size());
    end

    $display("run complete: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+bench
hw/stage_pkg.sv
hw/coef_buf.sv
hw/act_unit.sv
hw/tb_dina_map.sv
hw/transpose_buf.sv
hw/stage_ctrl.sv
hw/stage_top.sv
bench/tb_stage_top.sv

// ==== hw/act_unit.sv ====
`timescale 1ns/10ps

module act_unit #(
  parameter int L      = 4,
  parameter int LANE_W = 16
) (
  input  logic                clk,
  input  logic                sys_rst,
  input  stage_pkg::act_e     i_act,
  input  logic [L*LANE_W-1:0] i_row,
  output logic [L*LANE_W-1:0] o_raw,
  output logic [L*LANE_W-1:0] o_act
);

  import stage_pkg::*;

  logic [L*LANE_W-1:0] act_d;

  always_comb begin : lane_act
    logic signed [LANE_W-1:0] lane;
    act_d = '0;
    lane  = '0;
    for (int k = 0; k < L; k++) begin
      lane = i_row[k*LANE_W +: LANE_W];
      if (lane < 0) begin
        if (i_act == ACT_LEAKY) begin
          act_d[k*LANE_W +: LANE_W] = lane >>> LEAKY_SHIFT;  // keeps sign
        end else begin
          act_d[k*LANE_W +: LANE_W] = '0;  // relu
        end
      end else begin
        act_d[k*LANE_W +: LANE_W] = lane;
      end
    end
  end

  // raw copy rides along so both rows leave together
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_raw <= '0;
      o_act <= '0;
    end else begin
      o_raw <= i_row;
      o_act <= act_d;
    end
  end

endmodule

// ==== hw/coef_buf.sv ====
`timescale 1ns/10ps

module coef_buf #(
  parameter int L        = 4,
  parameter int LANE_W   = 16,
  parameter int CB_DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        sys_rst,
  input  logic                        i_we,
  input  logic [$clog2(CB_DEPTH)-1:0] i_waddr,
  input  logic [L*LANE_W-1:0]         i_wdata,
  input  logic [$clog2(CB_DEPTH)-1:0] i_raddr,
  output logic [L*LANE_W-1:0]         o_rdata
);

  logic [L*LANE_W-1:0] mem [CB_DEPTH];  // one full row per entry

  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // registered read, one cycle after the address
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_rdata <= '0;
    end else begin
      o_rdata <= mem[i_raddr];  // old row on same-address write
    end
  end

endmodule

// ==== hw/stage_ctrl.sv ====
`timescale 1ns/10ps

module stage_ctrl #(
  parameter int L        = 4,
  parameter int CB_DEPTH = 16,
  parameter int CREDITS  = 4
) (
  input  logic                        clk,
  input  logic                        sys_rst,
  input  logic                        i_cmd_valid,
  input  stage_pkg::src_e             i_cmd_src,
  input  stage_pkg::act_e             i_cmd_act,
  input  stage_pkg::dir_e             i_cmd_dir,
  input  logic                        i_cmd_half,
  input  logic [$clog2(CB_DEPTH)-1:0] i_cmd_addr,
  input  logic [$clog2(L)-1:0]        i_cmd_row,
  output logic [$clog2(CB_DEPTH)-1:0] o_cb_raddr,
  output stage_pkg::act_e             o_act,
  output stage_pkg::src_e             o_src,
  output stage_pkg::dir_e             o_dir,
  output logic                        o_half,
  output logic                        o_we,
  output logic [$clog2(L)-1:0]        o_wrow,
  output logic                        o_credit
);

  import stage_pkg::*;

  localparam int ADDR_W = $clog2(CB_DEPTH);
  localparam int ROW_W  = $clog2(L);
  localparam int CNT_W  = $clog2(CREDITS + 2);  // room to see an overrun

  logic [5:1]       vld;  // vld[n] is high after edge n-1
  logic [ADDR_W-1:0] addr1;
  act_e             act1, act2;
  src_e             src1, src2, src3;
  dir_e             dir1, dir2, dir3;
  logic             half1, half2, half3;
  logic [ROW_W-1:0] row1, row2, row3, row4;
  logic [CNT_W-1:0] inflight;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      vld   <= '0;
      addr1 <= '0;
      act1  <= ACT_RELU;
      act2  <= ACT_RELU;
      src1  <= SRC_COEF;
      src2  <= SRC_COEF;
      src3  <= SRC_COEF;
      dir1  <= DIR_IDLE;
      dir2  <= DIR_IDLE;
      dir3  <= DIR_IDLE;
      half1 <= 1'b0;
      half2 <= 1'b0;
      half3 <= 1'b0;
      row1  <= '0;
      row2  <= '0;
      row3  <= '0;
      row4  <= '0;
    end else begin
      vld <= {vld[4:1], i_cmd_valid};
      if (i_cmd_valid) begin
        addr1 <= i_cmd_addr;
        act1  <= i_cmd_act;
        src1  <= i_cmd_src;
        half1 <= i_cmd_half;
        row1  <= i_cmd_row;
      end
      dir1  <= i_cmd_valid ? i_cmd_dir : DIR_IDLE;  // mapper idles between commands
      act2  <= act1;
      src2  <= src1;
      src3  <= src2;
      dir2  <= dir1;
      dir3  <= dir2;
      half2 <= half1;
      half3 <= half2;
      row2  <= row1;
      row3  <= row2;
      row4  <= row3;
    end
  end

  assign o_cb_raddr = addr1;  // read sampled at edge 1
  assign o_act      = act2;   // act stage samples at edge 2
  assign o_src      = src3;   // mapper samples at edge 3
  assign o_dir      = dir3;
  assign o_half     = half3;
  assign o_we       = vld[4];  // buffer write at edge 4
  assign o_wrow     = row4;
  assign o_credit   = vld[5];  // write stage delayed one, credit after the write

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      inflight <= '0;
    end else begin
      inflight <= inflight + CNT_W'(i_cmd_valid) - CNT_W'(o_credit);
    end
  end

  a_credit_limit: assert property (
    @(posedge clk) disable iff (sys_rst) int'(inflight) <= CREDITS
  ) else $error("stage_ctrl: %0d commands in flight, limit %0d", inflight, CREDITS);

  a_addr_range: assert property (
    @(posedge clk) disable iff (sys_rst) i_cmd_valid |-> int'(i_cmd_addr) < CB_DEPTH
  ) else $error("stage_ctrl: command address %0d beyond buffer", i_cmd_addr);

endmodule

// ==== hw/stage_pkg.sv ====
package stage_pkg;

  // row source for the mapper
  typedef enum logic {
    SRC_COEF = 1'b0,  // raw coefficient row
    SRC_NL   = 1'b1   // activated row
  } src_e;

  // lane direction codes of the mapper
  typedef enum logic [1:0] {
    DIR_IDLE = 2'b00,
    DIR_POS  = 2'b01,
    DIR_NEG  = 2'b10,
    DIR_NEW  = 2'b11  // half placement picked by i_half
  } dir_e;

  typedef enum logic {
    ACT_RELU  = 1'b0,
    ACT_LEAKY = 1'b1
  } act_e;

  // negative lanes under leaky are divided by 2**LEAKY_SHIFT
  localparam int LEAKY_SHIFT = 3;

endpackage

// ==== hw/stage_top.sv ====
`timescale 1ns/10ps

module stage_top #(
  parameter int L        = 4,
  parameter int LANE_W   = 16,
  parameter int CB_DEPTH = 16,
  parameter int CREDITS  = 4
) (
  input  logic                        clk,
  input  logic                        sys_rst,
  // coefficient load
  input  logic                        i_cb_we,
  input  logic [$clog2(CB_DEPTH)-1:0] i_cb_waddr,
  input  logic [L*LANE_W-1:0]         i_cb_wdata,
  // commands, one per credit
  input  logic                        i_cmd_valid,
  input  stage_pkg::src_e             i_cmd_src,
  input  stage_pkg::act_e             i_cmd_act,
  input  stage_pkg::dir_e             i_cmd_dir,
  input  logic                        i_cmd_half,
  input  logic [$clog2(CB_DEPTH)-1:0] i_cmd_addr,
  input  logic [$clog2(L)-1:0]        i_cmd_row,
  output logic                        o_credit,
  // column read-back
  input  logic [$clog2(L)-1:0]        i_rd_col,
  output logic [L*LANE_W-1:0]         o_rd_data
);

  import stage_pkg::*;

  logic [$clog2(CB_DEPTH)-1:0] cb_raddr;
  logic [L*LANE_W-1:0]         cb_rdata;
  act_e                        act_sel;
  src_e                        map_src;
  dir_e                        map_dir;
  logic                        map_half;
  logic [L*LANE_W-1:0]         raw_row;
  logic [L*LANE_W-1:0]         act_row;
  logic [L*LANE_W-1:0]         dina;
  logic                        tb_we;
  logic [$clog2(L)-1:0]        tb_wrow;

  stage_ctrl #(
    .L        (L),
    .CB_DEPTH (CB_DEPTH),
    .CREDITS  (CREDITS)
  ) u_ctrl (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd_src   (i_cmd_src),
    .i_cmd_act   (i_cmd_act),
    .i_cmd_dir   (i_cmd_dir),
    .i_cmd_half  (i_cmd_half),
    .i_cmd_addr  (i_cmd_addr),
    .i_cmd_row   (i_cmd_row),
    .o_cb_raddr  (cb_raddr),
    .o_act       (act_sel),
    .o_src       (map_src),
    .o_dir       (map_dir),
    .o_half      (map_half),
    .o_we        (tb_we),
    .o_wrow      (tb_wrow),
    .o_credit    (o_credit)
  );

  coef_buf #(
    .L        (L),
    .LANE_W   (LANE_W),
    .CB_DEPTH (CB_DEPTH)
  ) u_coef_buf (
    .clk     (clk),
    .sys_rst (sys_rst),
    .i_we    (i_cb_we),
    .i_waddr (i_cb_waddr),
    .i_wdata (i_cb_wdata),
    .i_raddr (cb_raddr),
    .o_rdata (cb_rdata)
  );

  act_unit #(
    .L      (L),
    .LANE_W (LANE_W)
  ) u_act (
    .clk     (clk),
    .sys_rst (sys_rst),
    .i_act   (act_sel),
    .i_row   (cb_rdata),
    .o_raw   (raw_row),
    .o_act   (act_row)
  );

  tb_dina_map #(
    .L      (L),
    .LANE_W (LANE_W)
  ) u_map (
    .clk     (clk),
    .sys_rst (sys_rst),
    .i_src   (map_src),
    .i_dir   (map_dir),
    .i_half  (map_half),
    .i_raw   (raw_row),
    .i_act   (act_row),
    .o_dina  (dina)
  );

  transpose_buf #(
    .L      (L),
    .LANE_W (LANE_W)
  ) u_tbuf (
    .clk     (clk),
    .sys_rst (sys_rst),
    .i_we    (tb_we),
    .i_wrow  (tb_wrow),
    .i_wdata (dina),
    .i_rcol  (i_rd_col),
    .o_rdata (o_rd_data)
  );

endmodule

// ==== hw/tb_dina_map.sv ====
`timescale 1ns/10ps

module tb_dina_map #(
  parameter int L      = 4,
  parameter int LANE_W = 16
) (
  input  logic                clk,
  input  logic                sys_rst,
  input  stage_pkg::src_e     i_src,
  input  stage_pkg::dir_e     i_dir,
  input  logic                i_half,
  input  logic [L*LANE_W-1:0] i_raw,
  input  logic [L*LANE_W-1:0] i_act,
  output logic [L*LANE_W-1:0] o_dina
);

  import stage_pkg::*;

  localparam int HALF = L / 2;

  logic [L*LANE_W-1:0] sel_row;
  logic [L*LANE_W-1:0] map_d;

  assign sel_row = (i_src == SRC_NL) ? i_act : i_raw;

  always_comb begin
    map_d = '0;
    case (i_dir)
      DIR_POS: begin
        map_d = sel_row;
      end
      DIR_NEG: begin
        for (int k = 0; k < L; k++) begin
          map_d[k*LANE_W +: LANE_W] = sel_row[(L-1-k)*LANE_W +: LANE_W];  // lane reversal
        end
      end
      DIR_NEW: begin
        // first half of the source goes low or high, the rest stays zero
        for (int k = 0; k < HALF; k++) begin
          if (i_half) begin
            map_d[k*LANE_W +: LANE_W] = sel_row[k*LANE_W +: LANE_W];
          end else begin
            map_d[(k+HALF)*LANE_W +: LANE_W] = sel_row[k*LANE_W +: LANE_W];
          end
        end
      end
      default: begin
        map_d = '0;  // idle
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_dina <= '0;
    end else begin
      o_dina <= map_d;
    end
  end

endmodule

// ==== hw/transpose_buf.sv ====
`timescale 1ns/10ps

module transpose_buf #(
  parameter int L      = 4,
  parameter int LANE_W = 16
) (
  input  logic                 clk,
  input  logic                 sys_rst,
  input  logic                 i_we,
  input  logic [$clog2(L)-1:0] i_wrow,
  input  logic [L*LANE_W-1:0]  i_wdata,
  input  logic [$clog2(L)-1:0] i_rcol,
  output logic [L*LANE_W-1:0]  o_rdata
);

  logic [LANE_W-1:0] cells [L][L];  // [row][lane]

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      for (int r = 0; r < L; r++) begin
        for (int c = 0; c < L; c++) begin
          cells[r][c] <= '0;
        end
      end
      o_rdata <= '0;
    end else begin
      if (i_we) begin
        for (int c = 0; c < L; c++) begin
          cells[i_wrow][c] <= i_wdata[c*LANE_W +: LANE_W];
        end
      end
      // lane r of the output is column i_rcol of row r
      for (int r = 0; r < L; r++) begin
        o_rdata[r*LANE_W +: LANE_W] <= cells[r][i_rcol];  // pre-write contents
      end
    end
  end

  // row and column selects only reach L when L is not a power of two
  a_index_range: assert property (
    @(posedge clk) disable iff (sys_rst)
    (!i_we || int'(i_wrow) < L) && int'(i_rcol) < L
  ) else $error("transpose_buf index out of range, row %0d col %0d", i_wrow, i_rcol);

endmodule
